/* fabric_testdata.txt */
# W addr data | N name | D west east north south exp_east exp_north exp_south
# hex fields; addr holds the section code in 31:16 and tile id in 15:0, tile 1 is row 0
N reset_idle
D 00 00 0 0 00 0 0
N default_route
D 00 5a 3 0 33 a 3
N route_row0
W 00070001 0055aa55
D 06 9c 0 0 c9 6 c
D 03 5a 0 0 a5 3 a
N cross_rows
W 00070001 000000aa
W 00070002 000055aa
D b0 00 5 e b5 e 5
N clb_and
W 00070001 00005755
W 00060001 00000005
W 00050001 00000002
W 00040001 00000000
D 02 04 0 0 02 2 0
D 02 00 0 0 03 2 0
N clb_or
W 00040001 00000001
D 00 04 0 0 00 0 0
D 00 00 0 0 01 0 0
N clb_xor
W 00040001 00000002
D 02 04 0 0 02 2 0
D 02 00 0 0 02 2 0
D 00 00 0 0 01 0 0
N clb_nand
W 00040001 00000003
D 02 04 0 0 02 2 0
D 00 00 0 0 00 0 0
D 00 00 0 0 01 0 0
N addressing
W 00070003 00ffffff
W 00030001 00ffffff
D 0a 50 3 0 0b a 3

/* flist.f */
fabric_cfg_pkg.sv
fabric_route_pkg.sv
connect_box.sv
switch_box_left.sv
clb.sv
pe_tile_left.sv
fabric_column.sv
fabric_column_sva.sv
tb_fabric_column.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fabric_column
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_fabric_column.sv */
`timescale 1ns/1ps

module tb_fabric_column
	import fabric_cfg_pkg::*;
	import fabric_route_pkg::*;
();

	localparam int NUM_TILES = 2;
	localparam int SETTLE_TIMEOUT = 20;	// cycles.
	localparam int MAX_RECORDS = 1000;

	logic clk;
	logic reset;
	cfg_addr_t config_addr;
	cfg_data_t config_data;
	logic [NUM_TILES*NUM_TRACKS-1:0] west_in;
	logic [NUM_TILES*NUM_TRACKS-1:0] east_in;
	logic [NUM_TILES*NUM_TRACKS-1:0] east_out;
	track_t north_in;
	track_t south_in;
	track_t north_out;
	track_t south_out;
	logic [8*32-1:0] test_name;

	fabric_column #(
		.NUM_TILES   (NUM_TILES),
		.TILE_ID_BASE(1)
	) u_fabric_column (
		.clk        (clk),
		.reset      (reset),
		.config_addr(config_addr),
		.config_data(config_data),
		.west_in    (west_in),
		.east_in    (east_in),
		.north_in   (north_in),
		.south_in   (south_in),
		.east_out   (east_out),
		.north_out  (north_out),
		.south_out  (south_out)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%0s", reason);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string label, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] test %0s, %0s: expected %0h, actual %0h",
				test_name, label, expected, actual);
			$display("Testbench failed");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic wait_for_idle();
		int cycles;
		cycles = 0;
		while ({east_out, north_out, south_out} !== '0) begin
			if (cycles >= SETTLE_TIMEOUT) begin
				abort_run("timeout: outputs did not return to zero after reset");
			end
			@(posedge clk);
			#1;
			cycles++;
		end
	endtask

	initial begin
		int fd, code, records, vectors;
		logic [31:0] noise, w_addr, w_data;
		logic [7:0] kind, v_west, v_east, x_east;
		logic [3:0] v_north, v_south, x_north, x_south;
		logic [8*256-1:0] line_buf;
		clk = 1'b0;
		reset = 1'b1;
		config_addr = '0;
		config_data = '0;
		west_in = '0;
		east_in = '0;
		north_in = '0;
		south_in = '0;
		test_name = "reset";
		noise = $urandom(56314);

		////////////////////
		// reset with idle noise
		////////////////////
		repeat (16) begin
			@(posedge clk);
			#1;
			noise = $urandom;
			west_in = noise[7:0];
			east_in = noise[15:8];
			north_in = noise[19:16];
			south_in = noise[23:20];
			config_data = $urandom;
		end
		reset = 1'b0;
		west_in = '0;
		east_in = '0;
		north_in = '0;
		south_in = '0;
		wait_for_idle();

		////////////////////
		// replay the data file
		////////////////////
		fd = $fopen("fabric_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open fabric_testdata.txt");
		end
		records = 0;
		vectors = 0;
		while (!$feof(fd) && records < MAX_RECORDS) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				if (!$feof(fd)) begin
					abort_run("unreadable record in fabric_testdata.txt");
				end
			end else if (kind == "#") begin
				code = $fgets(line_buf, fd);
			end else if (kind == "N") begin
				if ($fscanf(fd, "%s", test_name) != 1) begin
					abort_run("malformed N record in fabric_testdata.txt");
				end
			end else if (kind == "W") begin
				if ($fscanf(fd, "%h %h", w_addr, w_data) != 2) begin
					abort_run("malformed W record in fabric_testdata.txt");
				end
				config_addr = w_addr;
				config_data = w_data;
				@(posedge clk);
				#1;
				records++;
			end else if (kind == "D") begin
				if ($fscanf(fd, "%h %h %h %h %h %h %h", v_west, v_east, v_north, v_south,
						x_east, x_north, x_south) != 7) begin
					abort_run("malformed D record in fabric_testdata.txt");
				end
				config_addr = '0;	// tile 0 matches no tile.
				config_data = $urandom;
				west_in = v_west;
				east_in = v_east;
				north_in = v_north;
				south_in = v_south;
				#8;	// just before the next rising edge.
				check_value("east_out", 32'(x_east), 32'(east_out));
				check_value("north_out", 32'(x_north), 32'(north_out));
				check_value("south_out", 32'(x_south), 32'(south_out));
				@(posedge clk);
				#1;
				records++;
				vectors++;
			end else begin
				abort_run("unknown record type in fabric_testdata.txt");
			end
		end
		$fclose(fd);
		if (records >= MAX_RECORDS) begin
			abort_run("record limit reached before the end of fabric_testdata.txt");
		end else if (vectors == 0) begin
			abort_run("no data vectors found in fabric_testdata.txt");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

/* fabric_column_sva.sv */
`timescale 1ns/1ps

module fabric_column_sva
	import fabric_cfg_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input cfg_addr_t config_addr,
	input tile_id_t  tile_id,
	input logic      config_en_sb,
	input logic      config_en_cb0,
	input logic      config_en_cb1,
	input logic      config_en_clb,
	input logic      pe_output
);

	logic [3:0] section_en;

	assign section_en = {config_en_sb, config_en_cb0, config_en_cb1, config_en_clb};

	a_enable_onehot: assert property (@(posedge clk) $onehot0(section_en))
		else $error("more than one section enable is high");

	a_enable_id: assert property (@(posedge clk)
		(config_addr[15:0] != tile_id) |-> (section_en == 4'b0))
		else $error("section enable raised for another tile id");

	// register cleared by the reset edge.
	a_clb_reset: assert property (@(posedge clk) reset |=> !pe_output)
		else $error("logic block output not cleared by reset");

endmodule

bind pe_tile_left fabric_column_sva u_sva (
	.clk          (clk),
	.reset        (reset),
	.config_addr  (config_addr),
	.tile_id      (TILE_ID),
	.config_en_sb (config_en_sb),
	.config_en_cb0(config_en_cb0),
	.config_en_cb1(config_en_cb1),
	.config_en_clb(config_en_clb),
	.pe_output    (pe_output)
);

/* fabric_column.sv */
`timescale 1ns/1ps

module fabric_column
	import fabric_cfg_pkg::*;
	import fabric_route_pkg::*;
#(
	parameter int NUM_TILES    = 2,
	parameter int TILE_ID_BASE = 1
) (
	input  logic                            clk,
	input  logic                            reset,
	input  cfg_addr_t                       config_addr,
	input  cfg_data_t                       config_data,
	input  logic [NUM_TILES*NUM_TRACKS-1:0] west_in,
	input  logic [NUM_TILES*NUM_TRACKS-1:0] east_in,
	input  track_t                          north_in,
	input  track_t                          south_in,
	output logic [NUM_TILES*NUM_TRACKS-1:0] east_out,
	output track_t                          north_out,
	output track_t                          south_out
);

	// per row, side 3 outputs heading south and side 0 outputs heading north.
	logic [NUM_TILES*NUM_TRACKS-1:0] down_tracks;
	logic [NUM_TILES*NUM_TRACKS-1:0] up_tracks;

	for (genvar r = 0; r < NUM_TILES; r++) begin : g_row
		track_t row_in_side0;
		track_t row_in_side3;

		if (r == 0) begin : g_top
			assign row_in_side0 = north_in;
		end else begin : g_top
			assign row_in_side0 = down_tracks[(r-1)*NUM_TRACKS +: NUM_TRACKS];
		end

		if (r == NUM_TILES - 1) begin : g_bottom
			assign row_in_side3 = south_in;
		end else begin : g_bottom
			assign row_in_side3 = up_tracks[(r+1)*NUM_TRACKS +: NUM_TRACKS];
		end

		pe_tile_left #(
			.TILE_ID(tile_id_t'(TILE_ID_BASE + r))
		) u_tile (
			.clk        (clk),
			.reset      (reset),
			.config_addr(config_addr),
			.config_data(config_data),
			.in_side0   (row_in_side0),
			.in_side1   (east_in[r*NUM_TRACKS +: NUM_TRACKS]),
			.in_side2   (west_in[r*NUM_TRACKS +: NUM_TRACKS]),
			.in_side3   (row_in_side3),
			.out_side0  (up_tracks[r*NUM_TRACKS +: NUM_TRACKS]),
			.out_side1  (east_out[r*NUM_TRACKS +: NUM_TRACKS]),
			.out_side3  (down_tracks[r*NUM_TRACKS +: NUM_TRACKS])
		);
	end

	assign north_out = up_tracks[0 +: NUM_TRACKS];
	assign south_out = down_tracks[(NUM_TILES-1)*NUM_TRACKS +: NUM_TRACKS];

endmodule

/* pe_tile_left.sv */
`timescale 1ns/1ps

module pe_tile_left
	import fabric_cfg_pkg::*;
	import fabric_route_pkg::*;
#(
	parameter tile_id_t TILE_ID = 16'd1
) (
	input  logic      clk,
	input  logic      reset,
	input  cfg_addr_t config_addr,
	input  cfg_data_t config_data,
	input  track_t    in_side0,
	input  track_t    in_side1,
	input  track_t    in_side2,
	input  track_t    in_side3,
	output track_t    out_side0,
	output track_t    out_side1,
	output track_t    out_side3
);

	logic op_0;
	logic op_1;
	logic pe_output;

	logic     id_match;
	section_t section;
	logic     config_en_sb;
	logic     config_en_cb0;
	logic     config_en_cb1;
	logic     config_en_clb;

	////////////////////
	// config decode
	////////////////////

	assign id_match = (addr_tile(config_addr) == TILE_ID);
	assign section  = addr_section(config_addr);

	assign config_en_sb  = id_match && (section == SECTION_SB);
	assign config_en_cb0 = id_match && (section == SECTION_CB0);
	assign config_en_cb1 = id_match && (section == SECTION_CB1);
	assign config_en_clb = id_match && (section == SECTION_CLB);

	connect_box cb0 (
		.clk        (clk),
		.reset      (reset),
		.config_en  (config_en_cb0),
		.config_data(config_data[2:0]),
		.side_in    (in_side0),
		.side_out   (out_side0),
		.block_out  (op_0)
	);

	connect_box cb1 (
		.clk        (clk),
		.reset      (reset),
		.config_en  (config_en_cb1),
		.config_data(config_data[2:0]),
		.side_in    (in_side1),
		.side_out   (out_side1),
		.block_out  (op_1)
	);

	switch_box_left sb (
		.clk        (clk),
		.reset      (reset),
		.config_en  (config_en_sb),
		.config_data(config_data),
		.in_side0   (in_side0),
		.in_side1   (in_side1),
		.in_side2   (in_side2),
		.in_side3   (in_side3),
		.pe_output  (pe_output),
		.out_side0  (out_side0),
		.out_side1  (out_side1),
		.out_side3  (out_side3)
	);

	clb compute_block (
		.clk        (clk),
		.reset      (reset),
		.config_en  (config_en_clb),
		.config_data(config_data[1:0]),
		.in0        (op_0),
		.in1        (op_1),
		.out        (pe_output)
	);

endmodule

/* clb.sv */
`timescale 1ns/1ps

module clb
	import fabric_route_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    config_en,
	input  clb_op_t config_data,
	input  logic    in0,
	input  logic    in1,
	output logic    out
);

	clb_op_t op;

	always_ff @(posedge clk) begin
		if (reset) begin
			op  <= CLB_AND;
			out <= 1'b0;
		end else begin
			if (config_en) begin
				op <= config_data;
			end
			case (op)
				CLB_AND:  out <= in0 & in1;
				CLB_OR:   out <= in0 | in1;
				CLB_XOR:  out <= in0 ^ in1;
				CLB_NAND: out <= ~(in0 & in1);
				default:  out <= 1'b0;
			endcase
		end
	end

endmodule

/* switch_box_left.sv */
`timescale 1ns/1ps

module switch_box_left
	import fabric_cfg_pkg::*;
	import fabric_route_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      config_en,
	input  cfg_data_t config_data,
	input  track_t    in_side0,
	input  track_t    in_side1,
	input  track_t    in_side2,
	input  track_t    in_side3,
	input  logic      pe_output,
	output track_t    out_side0,
	output track_t    out_side1,
	output track_t    out_side3
);

	logic [SB_CFG_BITS-1:0] route_cfg;

	// four-way pick for one output track.
	function automatic logic route_pick(
		input sb_sel_t sel,
		input logic    src_a,
		input logic    src_b,
		input logic    src_c,
		input logic    pe
	);
		case (sel)
			2'd0: route_pick = src_a;
			2'd1: route_pick = src_b;
			2'd2: route_pick = src_c;
			SB_SEL_PE: route_pick = pe;
			default: route_pick = 1'b0;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			route_cfg <= '0;
		end else if (config_en) begin
			route_cfg <= config_data[SB_CFG_BITS-1:0];
		end
	end

	////////////////////
	// output muxes
	////////////////////

	for (genvar t = 0; t < NUM_TRACKS; t++) begin : g_track
		sb_sel_t sel_n;
		sb_sel_t sel_e;
		sb_sel_t sel_s;

		assign sel_n = route_cfg[0*SB_SIDE_BITS + 2*t +: 2];
		assign sel_e = route_cfg[1*SB_SIDE_BITS + 2*t +: 2];
		assign sel_s = route_cfg[2*SB_SIDE_BITS + 2*t +: 2];

		// own side is never a source.
		assign out_side0[t] = route_pick(sel_n, in_side1[t], in_side2[t], in_side3[t], pe_output);
		assign out_side1[t] = route_pick(sel_e, in_side0[t], in_side2[t], in_side3[t], pe_output);
		assign out_side3[t] = route_pick(sel_s, in_side0[t], in_side1[t], in_side2[t], pe_output);
	end

endmodule

/* connect_box.sv */
`timescale 1ns/1ps

module connect_box
	import fabric_route_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    config_en,
	input  cb_sel_t config_data,
	input  track_t  side_in,
	input  track_t  side_out,
	output logic    block_out
);

	cb_sel_t sel;
	logic [2*NUM_TRACKS-1:0] tracks;

	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
		end else if (config_en) begin
			sel <= config_data;
		end
	end

	// upper half is the side's outgoing wires.
	assign tracks = {side_out, side_in};

	assign block_out = tracks[sel];

endmodule

/* fabric_route_pkg.sv */
package fabric_route_pkg;

	localparam int NUM_TRACKS = 4;	// per side.

	typedef logic [NUM_TRACKS-1:0] track_t;

	// 0..3 pick side inputs, 4..7 pick side outputs.
	typedef logic [2:0] cb_sel_t;

	// 0..2 pick the other input sides in ascending order, 3 picks the clb.
	typedef logic [1:0] sb_sel_t;
	localparam sb_sel_t SB_SEL_PE = 2'd3;

	// output sides 0, 1, 3 in that order, tracks ascending.
	localparam int SB_CFG_BITS = 24;
	localparam int SB_SIDE_BITS = SB_CFG_BITS / 3;

	typedef logic [1:0] clb_op_t;
	localparam clb_op_t CLB_AND  = 2'd0;
	localparam clb_op_t CLB_OR   = 2'd1;
	localparam clb_op_t CLB_XOR  = 2'd2;
	localparam clb_op_t CLB_NAND = 2'd3;

endpackage

/* fabric_cfg_pkg.sv */
package fabric_cfg_pkg;

	////////////////////
	// bus word types
	////////////////////

	typedef logic [31:0] cfg_addr_t;	// section code in 31:16, tile id in 15:0.
	typedef logic [31:0] cfg_data_t;
	typedef logic [15:0] tile_id_t;
	typedef logic [15:0] section_t;

	////////////////////
	// section codes
	////////////////////

	localparam section_t SECTION_SB  = 16'd7;
	localparam section_t SECTION_CB0 = 16'd6;
	localparam section_t SECTION_CB1 = 16'd5;
	localparam section_t SECTION_CLB = 16'd4;

	function automatic tile_id_t addr_tile(input cfg_addr_t addr);
		return addr[15:0];
	endfunction

	function automatic section_t addr_section(input cfg_addr_t addr);
		return addr[31:16];
	endfunction

endpackage
